// ==== common/controlPkg.sv ====
package controlPkg;

    // --------------------
    // Instruction encodings
    // --------------------

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    // SRL/ROTR and SRLV/ROTRV share a code
    typedef enum logic [5:0] {
        FN_SLL        = 6'b000000,
        FN_SRL_ROTR   = 6'b000010,
        FN_SLLV       = 6'b000100,
        FN_SRLV_ROTRV = 6'b000110,
        FN_JR         = 6'b001000
    } funct_e;

    typedef enum logic [5:0] {
        ALU_ZERO  = 6'b000000,
        ALU_ADDIU = 6'b000001,
        ALU_ADDI  = 6'b000010,
        ALU_LUI   = 6'b000100,
        ALU_JUMP  = 6'b001011,  // J, JR, JAL
        ALU_ANDI  = 6'b001100,
        ALU_ORI   = 6'b001101,
        ALU_XORI  = 6'b001110,
        ALU_SLTI  = 6'b010000,
        ALU_SLTIU = 6'b010001,
        ALU_SRL   = 6'b010010,
        ALU_ROTR  = 6'b010011,
        ALU_SRLV  = 6'b010100,
        ALU_ROTRV = 6'b010110
    } aluOp_e;

    typedef enum logic [1:0] {DST_RT = 2'b00, DST_RD = 2'b01, DST_RA = 2'b10} regDst_e;
    typedef enum logic [1:0] {WB_MEM = 2'b00, WB_LINK = 2'b01, WB_ALU = 2'b10} memToReg_e;
    typedef enum logic [1:0] {BS_WORD = 2'b00, BS_HALF = 2'b01, BS_BYTE = 2'b10} byteSel_e;

    // --------------------
    // Instruction formats
    // --------------------

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [25:0] target;
    } jFmt_t;

    // One fetched word seen three ways
    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
        jFmt_t jFmt;
    } instrWord_u;

    // --------------------
    // Control word
    // --------------------

    typedef struct packed {
        logic      aluBMux;  // 1 selects immediate
        regDst_e   regDst;
        aluOp_e    aluOp;
    } exCtrl_t;

    typedef struct packed {
        logic     memWrite;
        logic     memRead;
        byteSel_e byteSig;
    } memCtrl_t;

    typedef struct packed {
        logic      regWrite;
        memToReg_e memToReg;
    } wbCtrl_t;

    typedef struct packed {
        logic jumpMuxSel;   // Register target for JR
        logic jumpControl;
        logic flushIf;
    } jumpCtrl_t;

    // All zero means inactive
    typedef struct packed {
        jumpCtrl_t jump;
        exCtrl_t   ex;
        memCtrl_t  mem;
        wbCtrl_t   wb;
    } ctrlWord_t;

endpackage

// ==== decode/specialFuncDecoder.sv ====
`timescale 1ns/1ns

module specialFuncDecoder (
    input  controlPkg::instrWord_u instr,
    output controlPkg::ctrlWord_t  specialCtrl
);
    import controlPkg::*;

    logic [5:0] funct;
    logic       rotBit;     // Instruction bit 21
    logic       rotVarBit;  // Instruction bit 6

    // --------------------
    // Field extraction
    // --------------------

    assign funct     = instr.rFmt.funct;
    assign rotBit    = instr.rFmt.rs[0];
    assign rotVarBit = instr.rFmt.shamt[0];

    // --------------------
    // Function decode
    // --------------------

    always_comb begin
        specialCtrl = '0;

        if (funct == FN_JR) begin
            // Jump through rs and flush fetch
            specialCtrl.jump.jumpMuxSel  = 1'b1;
            specialCtrl.jump.jumpControl = 1'b1;
            specialCtrl.jump.flushIf     = 1'b1;
            specialCtrl.ex.aluOp         = ALU_JUMP;
        end else begin
            // Register-register result into rd
            specialCtrl.ex.aluBMux  = 1'b0;
            specialCtrl.ex.regDst   = DST_RD;
            specialCtrl.wb.regWrite = 1'b1;
            specialCtrl.wb.memToReg = WB_ALU;

            case (funct)
                FN_SRL_ROTR: begin
                    specialCtrl.ex.aluOp = rotBit ? ALU_ROTR : ALU_SRL;
                end
                FN_SRLV_ROTRV: begin
                    specialCtrl.ex.aluOp = rotVarBit ? ALU_ROTRV : ALU_SRLV;
                end
                default: begin
                    specialCtrl.ex.aluOp = ALU_ZERO;  // SLL, SLLV and the rest
                end
            endcase
        end
    end

endmodule

// ==== decode/opcodeDecoder.sv ====
`timescale 1ns/1ns

module opcodeDecoder (
    input  controlPkg::opcode_e   opcode,
    output controlPkg::ctrlWord_t opcodeCtrl
);
    import controlPkg::*;

    // --------------------
    // Helpers
    // --------------------

    // ALU op of the immediate group
    function automatic aluOp_e immAluOp(input opcode_e op);
        case (op)
            OP_ADDI:  return ALU_ADDI;
            OP_ADDIU: return ALU_ADDIU;
            OP_LUI:   return ALU_LUI;
            OP_ANDI:  return ALU_ANDI;
            OP_ORI:   return ALU_ORI;
            OP_XORI:  return ALU_XORI;
            OP_SLTI:  return ALU_SLTI;
            OP_SLTIU: return ALU_SLTIU;
            default:  return ALU_ZERO;
        endcase
    endfunction

    // Access size of a load or store
    function automatic byteSel_e accessSize(input opcode_e op);
        case (op)
            OP_LH, OP_SH: return BS_HALF;
            OP_LB, OP_SB: return BS_BYTE;
            default:      return BS_WORD;
        endcase
    endfunction

    // --------------------
    // Opcode decode
    // --------------------

    always_comb begin
        opcodeCtrl = '0;

        case (opcode)
            // Immediate arithmetic and logic
            OP_ADDI, OP_ADDIU, OP_LUI, OP_ANDI,
            OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU: begin
                opcodeCtrl.ex.aluBMux   = 1'b1;
                opcodeCtrl.ex.regDst    = DST_RT;
                opcodeCtrl.ex.aluOp     = immAluOp(opcode);
                opcodeCtrl.wb.regWrite  = 1'b1;
                opcodeCtrl.wb.memToReg  = WB_ALU;
            end

            // Loads address memory at rs + imm
            OP_LW, OP_LH, OP_LB: begin
                opcodeCtrl.ex.aluBMux   = 1'b1;
                opcodeCtrl.ex.regDst    = DST_RT;
                opcodeCtrl.ex.aluOp     = ALU_ADDI;
                opcodeCtrl.mem.memRead  = 1'b1;
                opcodeCtrl.mem.byteSig  = accessSize(opcode);
                opcodeCtrl.wb.regWrite  = 1'b1;
                opcodeCtrl.wb.memToReg  = WB_MEM;
            end

            // Stores
            OP_SW, OP_SH, OP_SB: begin
                opcodeCtrl.ex.aluBMux   = 1'b1;
                opcodeCtrl.ex.aluOp     = ALU_ADDI;
                opcodeCtrl.mem.memWrite = 1'b1;
                opcodeCtrl.mem.byteSig  = accessSize(opcode);
                opcodeCtrl.wb.regWrite  = 1'b0;
            end

            OP_J: begin
                opcodeCtrl.jump.jumpControl = 1'b1;
                opcodeCtrl.jump.flushIf     = 1'b1;
                opcodeCtrl.ex.aluOp         = ALU_JUMP;
            end

            OP_JAL: begin
                opcodeCtrl.jump.jumpControl = 1'b1;
                opcodeCtrl.jump.flushIf     = 1'b1;
                opcodeCtrl.ex.aluOp         = ALU_JUMP;
                opcodeCtrl.ex.regDst        = DST_RA;   // Link into r31
                opcodeCtrl.wb.regWrite      = 1'b1;
                opcodeCtrl.wb.memToReg      = WB_LINK;
            end

            default: begin
                opcodeCtrl = '0;
            end
        endcase
    end

endmodule

// ==== rtl/controlStage.sv ====
`timescale 1ns/1ns

module controlStage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instrValid,
    input  controlPkg::instrWord_u instr,
    input  controlPkg::ctrlWord_t  specialCtrl,
    input  controlPkg::ctrlWord_t  opcodeCtrl,
    output controlPkg::ctrlWord_t  ctrl,
    output logic                   ctrlValid
);
    import controlPkg::*;

    ctrlWord_t nextCtrl;
    logic      isNop;
    logic      isSpecial;

    // --------------------
    // Word select
    // --------------------

    assign isNop     = (instr == '0);
    assign isSpecial = (instr.iFmt.opcode == OP_SPECIAL);

    always_comb begin
        if (!instrValid || isNop) begin
            nextCtrl = '0;               // Bubble
        end else if (isSpecial) begin
            nextCtrl = specialCtrl;
        end else begin
            nextCtrl = opcodeCtrl;
        end
    end

    // --------------------
    // ID/EX register
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl      <= '0;
            ctrlValid <= 1'b0;
        end else begin
            ctrl      <= nextCtrl;
            ctrlValid <= instrValid;     // NOP still counts as valid
        end
    end

    // --------------------
    // Checks
    // --------------------

    // Memory stage gets at most one access per instruction
    memExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.mem.memRead && ctrl.mem.memWrite)
    ) else $error("memRead and memWrite both set");

    // Every fetch flush comes from a taken jump
    flushNeedsJump: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.jump.flushIf |-> ctrl.jump.jumpControl
    ) else $error("flushIf without jumpControl");

    // Empty slot carries no side effects downstream
    idleIsInactive: assert property (
        @(posedge clk) disable iff (rst)
        !ctrlValid |-> (ctrl == '0)
    ) else $error("ctrl active while ctrlValid low");

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instrValid,
    input  controlPkg::instrWord_u instr,
    output logic                   ctrlValid,
    output controlPkg::ctrlWord_t  ctrl
);
    import controlPkg::*;

    ctrlWord_t specialCtrl;
    ctrlWord_t opcodeCtrl;

    // --------------------
    // Decoders
    // --------------------

    // Both decoders see every word
    specialFuncDecoder specialDec (
        .instr       (instr),
        .specialCtrl (specialCtrl)
    );

    opcodeDecoder opcodeDec (
        .opcode     (instr.iFmt.opcode),
        .opcodeCtrl (opcodeCtrl)
    );

    // --------------------
    // Select and register
    // --------------------

    controlStage stage (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .specialCtrl (specialCtrl),
        .opcodeCtrl  (opcodeCtrl),
        .ctrl        (ctrl),
        .ctrlValid   (ctrlValid)
    );

endmodule

// ==== verification/controlRefModel.svh ====
// Expected control word from the decode rules
function automatic ctrlWord_t refControl(input instrWord_u word, input logic valid);
    ctrlWord_t   expected;
    logic [31:0] bits;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic        isImm;
    logic        isLoad;
    logic        isStore;

    expected = '0;
    bits     = word;
    op       = bits[31:26];
    fn       = bits[5:0];

    if (!valid || bits == 32'h0) begin
        return expected;  // Bubble or NOP
    end

    // --------------------
    // SPECIAL group
    // --------------------

    if (op == OP_SPECIAL) begin
        if (fn == FN_JR) begin
            expected.jump.jumpMuxSel  = 1'b1;
            expected.jump.jumpControl = 1'b1;
            expected.jump.flushIf     = 1'b1;
            expected.ex.aluOp         = ALU_JUMP;
        end else begin
            expected.ex.regDst   = DST_RD;
            expected.wb.regWrite = 1'b1;
            expected.wb.memToReg = WB_ALU;
            if (fn == FN_SRL_ROTR) begin
                expected.ex.aluOp = bits[21] ? ALU_ROTR : ALU_SRL;
            end else if (fn == FN_SRLV_ROTRV) begin
                expected.ex.aluOp = bits[6] ? ALU_ROTRV : ALU_SRLV;
            end else begin
                expected.ex.aluOp = ALU_ZERO;
            end
        end
        return expected;
    end

    // --------------------
    // Other opcodes
    // --------------------

    isLoad  = (op == OP_LW) || (op == OP_LH) || (op == OP_LB);
    isStore = (op == OP_SW) || (op == OP_SH) || (op == OP_SB);
    isImm   = 1'b1;
    case (op)
        OP_ADDI:  expected.ex.aluOp = ALU_ADDI;
        OP_ADDIU: expected.ex.aluOp = ALU_ADDIU;
        OP_LUI:   expected.ex.aluOp = ALU_LUI;
        OP_ANDI:  expected.ex.aluOp = ALU_ANDI;
        OP_ORI:   expected.ex.aluOp = ALU_ORI;
        OP_XORI:  expected.ex.aluOp = ALU_XORI;
        OP_SLTI:  expected.ex.aluOp = ALU_SLTI;
        OP_SLTIU: expected.ex.aluOp = ALU_SLTIU;
        default:  isImm = 1'b0;
    endcase

    if (isImm) begin
        expected.ex.aluBMux  = 1'b1;
        expected.ex.regDst   = DST_RT;
        expected.wb.regWrite = 1'b1;
        expected.wb.memToReg = WB_ALU;
    end

    if (isLoad || isStore) begin
        expected.ex.aluBMux  = 1'b1;
        expected.ex.aluOp    = ALU_ADDI;  // Base plus offset
        expected.mem.memRead  = isLoad;
        expected.mem.memWrite = isStore;
        expected.wb.regWrite  = isLoad;
        expected.wb.memToReg  = WB_MEM;
        if (op == OP_LH || op == OP_SH) begin
            expected.mem.byteSig = BS_HALF;
        end else if (op == OP_LB || op == OP_SB) begin
            expected.mem.byteSig = BS_BYTE;
        end else begin
            expected.mem.byteSig = BS_WORD;
        end
    end

    if (op == OP_J || op == OP_JAL) begin
        expected.jump.jumpControl = 1'b1;
        expected.jump.flushIf     = 1'b1;
        expected.ex.aluOp         = ALU_JUMP;
        if (op == OP_JAL) begin
            expected.ex.regDst   = DST_RA;
            expected.wb.regWrite = 1'b1;
            expected.wb.memToReg = WB_LINK;
        end
    end

    return expected;
endfunction

// ==== verification/controlUnitTb.sv ====
`timescale 1ns/1ns

module controlUnitTb;
    import controlPkg::*;

    `include "controlRefModel.svh"

    localparam int RESET_CYCLES = 4;
    localparam int WAIT_LIMIT   = 20;
    localparam int STREAM_LEN   = 500;

    logic       clk;
    logic       rst;
    logic       instrValid;
    instrWord_u instr;
    logic       ctrlValid;
    ctrlWord_t  ctrl;

    integer seed         = 32'ha6cff21c;
    int     checks       = 0;
    int     mismatches   = 0;
    int     timeouts     = 0;
    int     validIssued  = 0;
    int     validChecked = 0;

    controlUnit uut (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    always #2 clk = ~clk;

    // --------------------
    // Compare tasks
    // --------------------

    task automatic reportField(input string name, input logic [5:0] expected,
                               input logic [5:0] actual, input logic [31:0] word);
        if (expected !== actual) begin
            mismatches++;
            $display("mismatch %s: expected %h actual %h, instr %h",
                     name, expected, actual, word);
        end
    endtask

    task automatic checkCtrl(input ctrlWord_t expected, input ctrlWord_t actual,
                             input logic [31:0] word);
        reportField("ctrl.jump.jumpMuxSel", 6'(expected.jump.jumpMuxSel),
                    6'(actual.jump.jumpMuxSel), word);
        reportField("ctrl.jump.jumpControl", 6'(expected.jump.jumpControl),
                    6'(actual.jump.jumpControl), word);
        reportField("ctrl.jump.flushIf", 6'(expected.jump.flushIf),
                    6'(actual.jump.flushIf), word);
        reportField("ctrl.ex.aluBMux", 6'(expected.ex.aluBMux), 6'(actual.ex.aluBMux), word);
        reportField("ctrl.ex.regDst", 6'(expected.ex.regDst), 6'(actual.ex.regDst), word);
        reportField("ctrl.ex.aluOp", 6'(expected.ex.aluOp), 6'(actual.ex.aluOp), word);
        reportField("ctrl.mem.memWrite", 6'(expected.mem.memWrite),
                    6'(actual.mem.memWrite), word);
        reportField("ctrl.mem.memRead", 6'(expected.mem.memRead),
                    6'(actual.mem.memRead), word);
        reportField("ctrl.mem.byteSig", 6'(expected.mem.byteSig),
                    6'(actual.mem.byteSig), word);
        reportField("ctrl.wb.regWrite", 6'(expected.wb.regWrite),
                    6'(actual.wb.regWrite), word);
        reportField("ctrl.wb.memToReg", 6'(expected.wb.memToReg),
                    6'(actual.wb.memToReg), word);
    endtask

    task automatic checkValid(input logic expected, input logic actual,
                              input logic [31:0] word);
        if (expected !== actual) begin
            mismatches++;
            $display("mismatch ctrlValid: expected %h actual %h, instr %h",
                     expected, actual, word);
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    task automatic driveWord(input logic valid, input logic [31:0] word);
        @(posedge clk);
        instrValid <= valid;
        instr      <= word;
        if (valid) begin
            validIssued++;
        end
    endtask

    function automatic logic [31:0] makeSpecial(input logic [5:0] fn, input logic b21,
                                                input logic b6);
        logic [31:0] w;
        w        = $random(seed);
        w[31:26] = 6'b000000;
        w[21]    = b21;
        w[6]     = b6;
        w[5:0]   = fn;
        return w;
    endfunction

    // Random fields under a fixed opcode
    function automatic logic [31:0] makeOpWord(input logic [5:0] op);
        logic [31:0] w;
        w        = $random(seed);
        w[31:26] = op;
        return w;
    endfunction

    function automatic logic [5:0] functAt(input int i);
        case (i)
            0:       return FN_JR;
            1:       return FN_SRL_ROTR;
            2:       return FN_SRLV_ROTRV;
            3:       return FN_SLL;
            default: return FN_SLLV;
        endcase
    endfunction

    function automatic logic [5:0] memImmOpAt(input int i);
        case (i)
            0:       return OP_ADDI;
            1:       return OP_ADDIU;
            2:       return OP_LUI;
            3:       return OP_ANDI;
            4:       return OP_ORI;
            5:       return OP_XORI;
            6:       return OP_SLTI;
            7:       return OP_SLTIU;
            8:       return OP_LW;
            9:       return OP_LH;
            10:      return OP_LB;
            11:      return OP_SW;
            12:      return OP_SH;
            default: return OP_SB;
        endcase
    endfunction

    function automatic logic isKept(input logic [5:0] op);
        case (op)
            OP_SPECIAL, OP_J, OP_JAL, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW,
            OP_SB, OP_SH, OP_SW: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    function automatic logic [5:0] unknownOpcode();
        logic [31:0] r;
        int          tries;
        r     = $random(seed);
        tries = 0;
        while (isKept(r[5:0]) && tries < 64) begin
            r = $random(seed);
            tries++;
        end
        return isKept(r[5:0]) ? 6'b111111 : r[5:0];
    endfunction

    // Any kind of word including NOP
    function automatic logic [31:0] pickAny();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:       return 32'h0;
            3'd1:       return makeSpecial(functAt(int'(r[5:3]) % 5), r[6], r[7]);
            3'd2:       return makeSpecial(r[13:8], r[6], r[7]);
            3'd3, 3'd4: return makeOpWord(memImmOpAt(int'(r[6:3]) % 14));
            3'd5:       return makeOpWord(r[3] ? OP_JAL : OP_J);
            3'd6:       return makeOpWord(unknownOpcode());
            default:    return makeSpecial(FN_JR, r[6], r[7]);
        endcase
    endfunction

    task automatic waitForDrain();
        int waited;
        waited = 0;
        while (validChecked < validIssued && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (validChecked < validIssued) begin
            timeouts++;
            $display("timed out waiting for %0d outstanding results",
                     validIssued - validChecked);
        end
    endtask

    // --------------------
    // Compare process
    // --------------------

    initial begin : compareResults
        ctrlWord_t   expCtrl;
        logic        expValid;
        logic [31:0] expWord;
        int          waited;
        waited = 0;
        @(negedge clk);
        while (rst !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("reset was never released");
        end else begin
            checkCtrl('0, ctrl, instr);      // Still the reset value
            checkValid(1'b0, ctrlValid, instr);
            forever begin
                @(posedge clk);
                expWord  = instr;
                expValid = instrValid;
                expCtrl  = refControl(instr, instrValid);
                @(negedge clk);
                checkCtrl(expCtrl, ctrl, expWord);
                checkValid(expValid, ctrlValid, expWord);
                checks++;
                if (expValid) begin
                    validChecked++;
                end
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    initial begin : runStimulus
        logic [31:0] r;
        int          idx;
        int          bitPair;
        clk        = 1'b0;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        repeat (3) driveWord(1'b0, 32'h0);

        // NOP against bubbles
        driveWord(1'b1, 32'h0);
        driveWord(1'b0, 32'h0);
        driveWord(1'b0, makeSpecial(FN_JR, 1'b1, 1'b1));
        driveWord(1'b0, makeOpWord(OP_LW));
        driveWord(1'b1, 32'h0);

        for (bitPair = 0; bitPair < 4; bitPair++) begin
            for (idx = 0; idx < 5; idx++) begin
                driveWord(1'b1, makeSpecial(functAt(idx), bitPair[1], bitPair[0]));
            end
        end
        repeat (16) begin
            r = $random(seed);
            driveWord(1'b1, makeSpecial(r[5:0], r[6], r[7]));
        end

        for (idx = 0; idx < 14; idx++) begin
            driveWord(1'b1, makeOpWord(memImmOpAt(idx)));
            driveWord(1'b1, makeOpWord(memImmOpAt(idx)));
        end

        repeat (4) begin
            driveWord(1'b1, makeOpWord(OP_J));
            driveWord(1'b1, makeOpWord(OP_JAL));
        end
        repeat (16) driveWord(1'b1, makeOpWord(unknownOpcode()));

        // Back-to-back with random gaps
        repeat (STREAM_LEN) begin
            r = $random(seed);
            driveWord(r[2:0] != 3'b000, pickAny());
        end
        driveWord(1'b0, 32'h0);
        waitForDrain();

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verification
common/controlPkg.sv
decode/specialFuncDecoder.sv
decode/opcodeDecoder.sv
rtl/controlStage.sv
rtl/controlUnit.sv
verification/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module controlUnitTb \
    -f build.f \
    -o controlUnitSim

output=$(./obj_dir/controlUnitSim)
echo "$output"

if echo "$output" | grep -qF "** PASS **"; then
    exit 0
fi
exit 1
